// ==== qkv_block.f ====
+incdir+hw
+incdir+sim
hw/qkv_pkg.sv
hw/weight_store.sv
hw/proj_sequencer.sv
hw/mac_lane.sv
hw/result_collector.sv
hw/qkv_block.sv
sim/tb_qkv_block.sv

// ==== Bender.yml ====
package:
  name: qkv_block

sources:
  - include_dirs:
      - hw
    files:
      - hw/qkv_pkg.sv
      - hw/weight_store.sv
      - hw/proj_sequencer.sv
      - hw/mac_lane.sv
      - hw/result_collector.sv
      - hw/qkv_block.sv
  - target: simulation
    include_dirs:
      - hw
      - sim
    files:
      - sim/tb_qkv_block.sv

// ==== sim/tb_qkv_checks.svh ====
`ifndef TB_QKV_CHECKS_SVH
`define TB_QKV_CHECKS_SVH

////////////////////////////////////////
// pseudo random bits
////////////////////////////////////////

logic [31:0] lfsr_state = 32'hd0df_8e8e;

// galois form, taps 32 22 2 1
function automatic logic take_bit();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out_bit;
endfunction

// one step per bit of the word
function automatic word_t rand_word();
    word_t w;
    for (int b = 0; b < `QKV_DW; b++) begin
        w[b] = take_bit();
    end
    return w;
endfunction

////////////////////////////////////////
// compare tasks
////////////////////////////////////////

task automatic check_frame(input string name, input qkv_frame_t exp, input qkv_frame_t act);
    if (act !== exp) begin
        $display("FAIL %s: expected %h, actual %h", name, exp, act);
        $display("RESULT: FAIL");
        $fatal(1, "frame mismatch in %s", name);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAIL %s: expected %b, actual %b", name, exp, act);
        $display("RESULT: FAIL");
        $fatal(1, "flag mismatch in %s", name);
    end
endtask

`endif

// ==== sim/tb_qkv_block.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qkv_defs.svh"

module tb_qkv_block
    import qkv_pkg::*;
();

    localparam int clk_period = 100;
    localparam int depth      = `QKV_H_MAX * `QKV_X_LEN;
    localparam int n_rows     = 5;

    typedef enum logic {
        fill_lfsr,
        fill_max
    } fill_t;

    typedef struct {
        string      name;
        logic [1:0] h_count;
        fill_t      w_mode;
        fill_t      x_mode;
        int         ff_delay;
        logic       inject;
    } row_t;

    // name, heads, weights, x, ff_rdy delay, writes during the run
    row_t rows [n_rows] = '{
        '{"one_head_lfsr",           2'd1, fill_lfsr, fill_lfsr, 0, 1'b0},
        '{"two_head_max_wrap",       2'd2, fill_max,  fill_max,  0, 1'b0},
        '{"two_head_backpressure",   2'd2, fill_lfsr, fill_lfsr, 7, 1'b0},
        '{"two_head_mid_run_writes", 2'd2, fill_lfsr, fill_max,  3, 1'b1},
        '{"one_head_max_w_writes",   2'd1, fill_max,  fill_lfsr, 2, 1'b1}
    };

    logic       clk         = 1'b0;
    logic       rst_cnt_new = 1'b1;
    logic       start       = 1'b0;
    logic [1:0] h_count     = '0;
    x_vec_t     x_vec       = '0;
    wr_req_t    wr_req      = '0;
    logic       ff_rdy      = 1'b0;
    qkv_frame_t data_out;
    logic       output_rdy;
    logic       done;

    // copy of every bank, indexed by matrix then address
    wrow_t wmem [3][depth];

    always #(clk_period / 2) clk = ~clk;

    qkv_block u_dut (
        .clk         (clk),
        .rst_cnt_new (rst_cnt_new),
        .start       (start),
        .h_count     (h_count),
        .x_vec       (x_vec),
        .wr_req      (wr_req),
        .ff_rdy      (ff_rdy),
        .data_out    (data_out),
        .output_rdy  (output_rdy),
        .done        (done)
    );

    `include "tb_qkv_checks.svh"

    task automatic load_weights(input fill_t mode);
        wrow_t row;
        for (int m = 0; m < 3; m++) begin
            for (int a = 0; a < depth; a++) begin
                for (int i = 0; i < `QKV_DIM; i++) begin
                    row[i] = (mode == fill_max) ? word_t'('1) : rand_word();
                end
                wmem[m][a] = row;
                @(posedge clk);
                wr_req <= '{en: 1'b1, wr: 1'b1, sel: mat_sel_t'(m),
                            addr: `QKV_ADDR_W'(a), data: row};
            end
        end
        @(posedge clk);
        wr_req <= '0;
    endtask

    // wrapping double width dot product, upper half kept, idle heads zero
    function automatic qkv_frame_t build_expected(input logic [1:0] h_cnt, input x_vec_t x);
        qkv_frame_t f;
        proj_t      p;
        acc_t       acc;
        f = '0;
        for (int h = 0; h < int'(h_cnt); h++) begin
            for (int m = 0; m < 3; m++) begin
                for (int i = 0; i < `QKV_DIM; i++) begin
                    acc = '0;
                    for (int c = 0; c < `QKV_X_LEN; c++) begin
                        acc = acc + acc_t'(wmem[m][h * `QKV_X_LEN + c][i]) * acc_t'(x[c]);
                    end
                    p[i] = acc[2*`QKV_DW-1 -: `QKV_DW];
                end
                case (m)
                    0:       f[h].q = p;
                    1:       f[h].k = p;
                    default: f[h].v = p;
                endcase
            end
        end
        return f;
    endfunction

    task automatic run_row(input row_t r);
        qkv_frame_t expected;
        x_vec_t     xv;
        wrow_t      inj;
        load_weights(r.w_mode);
        for (int c = 0; c < `QKV_X_LEN; c++) begin
            xv[c] = (r.x_mode == fill_max) ? word_t'('1) : rand_word();
        end
        expected = build_expected(r.h_count, xv);
        @(posedge clk);
        x_vec   <= xv;
        h_count <= r.h_count;
        @(posedge clk);
        start <= 1'b1;
        @(negedge clk);
        while (done) begin
            @(negedge clk);
        end
        @(posedge clk);
        start <= 1'b0;
        // these land while the banks are being read
        if (r.inject) begin
            for (int n = 0; n < `QKV_X_LEN; n++) begin
                for (int i = 0; i < `QKV_DIM; i++) begin
                    inj[i] = rand_word();
                end
                wr_req <= '{en: 1'b1, wr: 1'b1, sel: mat_sel_t'(n % 3),
                            addr: `QKV_ADDR_W'(n), data: inj};
                @(posedge clk);
            end
            wr_req <= '0;
        end
        @(negedge clk);
        while (!output_rdy) begin
            @(negedge clk);
        end
        check_flag({r.name, " done with output_rdy"}, 1'b1, done);
        check_frame(r.name, expected, data_out);

        ////////////////////////////////////////
        // back-pressure with start held high
        ////////////////////////////////////////
        for (int d = 0; d < r.ff_delay; d++) begin
            @(posedge clk);
            start <= 1'b1;
            @(negedge clk);
            check_frame({r.name, " held"}, expected, data_out);
            check_flag({r.name, " output_rdy held"}, 1'b1, output_rdy);
            check_flag({r.name, " done held"}, 1'b1, done);
        end
        @(posedge clk);
        start  <= 1'b0;
        ff_rdy <= 1'b1;
        @(negedge clk);
        check_frame({r.name, " held"}, expected, data_out);
        check_flag({r.name, " output_rdy held"}, 1'b1, output_rdy);
        check_flag({r.name, " done held"}, 1'b1, done);
        @(posedge clk);
        ff_rdy <= 1'b0;
        @(negedge clk);
        check_flag({r.name, " output_rdy released"}, 1'b0, output_rdy);
        check_flag({r.name, " done after release"}, 1'b1, done);
        check_frame({r.name, " cleared"}, '0, data_out);
    endtask

    // reset, then per row a weight load, the longest run and the release
    function automatic longint run_budget();
        longint cycles;
        cycles = 10 + 20;
        for (int r = 0; r < n_rows; r++) begin
            cycles += 3 * depth + 2;
            cycles += 3 * `QKV_H_MAX * `QKV_X_LEN + 20 + rows[r].ff_delay;
        end
        return cycles;
    endfunction

    initial begin : watchdog
        longint limit;
        limit = run_budget();
        #(limit * clk_period);
        $display("timeout: the run did not finish in the expected number of cycles");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        repeat (10) @(posedge clk);
        rst_cnt_new <= 1'b0;
        @(negedge clk);
        check_flag("reset done", 1'b1, done);
        check_flag("reset output_rdy", 1'b0, output_rdy);
        for (int r = 0; r < n_rows; r++) begin
            run_row(rows[r]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/qkv_block.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qkv_defs.svh"

module qkv_block
    import qkv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_cnt_new,
    input  logic       start,
    input  logic [1:0] h_count,
    input  x_vec_t     x_vec,
    input  wr_req_t    wr_req,
    input  logic       ff_rdy,
    output qkv_frame_t data_out,
    output logic       output_rdy,
    output logic       done
);

    logic                   busy;
    logic                   run_start;
    logic                   frame_pending;
    logic                   rd_en;
    mat_sel_t               rd_sel;
    logic [`QKV_ADDR_W-1:0] rd_addr;
    wrow_t                  rd_data;
    lane_beat_t             beat;
    slot_t                  slot;
    logic [`QKV_DIM-1:0]    res_valid;
    proj_t                  res_words;

    weight_store u_store (
        .clk         (clk),
        .rst_cnt_new (rst_cnt_new),
        .busy        (busy),
        .wr_req      (wr_req),
        .rd_en       (rd_en),
        .rd_sel      (rd_sel),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    proj_sequencer u_seq (
        .clk           (clk),
        .rst_cnt_new   (rst_cnt_new),
        .start         (start),
        .h_count       (h_count),
        .x_vec         (x_vec),
        .frame_pending (frame_pending),
        .busy          (busy),
        .done          (done),
        .run_start     (run_start),
        .rd_en         (rd_en),
        .rd_sel        (rd_sel),
        .rd_addr       (rd_addr),
        .beat          (beat),
        .slot          (slot)
    );

    // lane i owns output word i
    for (genvar i = 0; i < `QKV_DIM; i++) begin : g_lane
        mac_lane u_lane (
            .clk         (clk),
            .rst_cnt_new (rst_cnt_new),
            .beat        (beat),
            .w           (rd_data[i]),
            .res_valid   (res_valid[i]),
            .res_word    (res_words[i])
        );
    end

    result_collector u_coll (
        .clk           (clk),
        .rst_cnt_new   (rst_cnt_new),
        .run_start     (run_start),
        .h_count       (h_count),
        .beat          (beat),
        .slot          (slot),
        .res_valid     (res_valid),
        .res_words     (res_words),
        .ff_rdy        (ff_rdy),
        .frame_pending (frame_pending),
        .output_rdy    (output_rdy),
        .data_out      (data_out)
    );

endmodule

`default_nettype wire

// ==== hw/result_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qkv_defs.svh"

module result_collector
    import qkv_pkg::*;
(
    input  logic               clk,
    input  logic               rst_cnt_new,
    input  logic               run_start,
    input  logic [1:0]         h_count,
    input  lane_beat_t         beat,
    input  slot_t              slot,
    input  logic [`QKV_DIM-1:0] res_valid,
    input  proj_t              res_words,
    input  logic               ff_rdy,
    output logic               frame_pending,
    output logic               output_rdy,
    output qkv_frame_t         data_out
);

    localparam int pass_w = $clog2(3 * `QKV_H_MAX + 1);

    slot_t             slot_q;
    logic [1:0]        h_cnt_q;
    logic [pass_w-1:0] pass_cnt;
    logic              pass_last;

    // a held frame blocks the next run
    assign frame_pending = output_rdy;

    assign pass_last = (pass_cnt == pass_w'(3 * h_cnt_q - 1));

    always_ff @(posedge clk) begin
        if (rst_cnt_new) begin
            slot_q     <= '0;
            h_cnt_q    <= '0;
            pass_cnt   <= '0;
            output_rdy <= 1'b0;
            data_out   <= '0;
        end else begin
            // slot belongs to the pass that starts here
            if (beat.valid && beat.first) begin
                slot_q <= slot;
            end
            if (run_start) begin
                h_cnt_q  <= h_count;
                pass_cnt <= '0;
                data_out <= '0;
            end else if (output_rdy && ff_rdy) begin
                output_rdy <= 1'b0;
                data_out   <= '0;
            end else if (res_valid[0]) begin
                case (slot_q.sel)
                    mat_q:   data_out[slot_q.head].q <= res_words;
                    mat_k:   data_out[slot_q.head].k <= res_words;
                    mat_v:   data_out[slot_q.head].v <= res_words;
                    default: ;
                endcase
                pass_cnt <= pass_cnt + 1'b1;
                if (pass_last) begin
                    output_rdy <= 1'b1;
                end
            end
        end
    end

    // lanes share one beat stream so they finish together
    a_lanes_aligned: assert property (@(posedge clk) disable iff (rst_cnt_new)
        (res_valid == '0) || (&res_valid));

endmodule

`default_nettype wire

// ==== hw/mac_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qkv_defs.svh"

module mac_lane
    import qkv_pkg::*;
(
    input  logic       clk,
    input  logic       rst_cnt_new,
    input  lane_beat_t beat,
    input  word_t      w,
    output logic       res_valid,
    output word_t      res_word
);

    acc_t acc;
    acc_t prod;
    acc_t acc_next;

    // unsigned product fits the accumulator exactly
    assign prod = acc_t'(w) * acc_t'(beat.x);

    // sum wraps at 2*DW bits
    assign acc_next = (beat.first ? acc_t'(0) : acc) + prod;

    always_ff @(posedge clk) begin
        if (rst_cnt_new) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= beat.valid && beat.last;
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            acc <= acc_next;
        end
        // keep only the upper half
        if (beat.valid && beat.last) begin
            res_word <= acc_next[2*`QKV_DW-1 -: `QKV_DW];
        end
    end

endmodule

`default_nettype wire

// ==== hw/proj_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qkv_defs.svh"

module proj_sequencer
    import qkv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_cnt_new,
    input  logic                   start,
    input  logic [1:0]             h_count,
    input  x_vec_t                 x_vec,
    input  logic                   frame_pending,
    output logic                   busy,
    output logic                   done,
    output logic                   run_start,
    output logic                   rd_en,
    output mat_sel_t               rd_sel,
    output logic [`QKV_ADDR_W-1:0] rd_addr,
    output lane_beat_t             beat,
    output slot_t                  slot
);

    localparam int col_w = $clog2(`QKV_X_LEN);

    typedef enum logic {
        st_idle,
        st_run
    } state_t;

    state_t           state;
    logic [1:0]       h_cnt_q;
    logic [1:0]       head_cnt;
    mat_sel_t         mat_cnt;
    logic [col_w-1:0] col_cnt;
    logic             accept;
    logic             col_end;
    logic             run_end;
    // final beat travels through read and lane before the frame is complete
    logic [1:0]       end_pipe;

    assign accept = (state == st_idle) && done && start && !frame_pending &&
                    (h_count != 2'd0) && (int'(h_count) <= `QKV_H_MAX);

    assign col_end = (col_cnt == col_w'(`QKV_X_LEN - 1));
    assign run_end = (state == st_run) && col_end && (mat_cnt == mat_v) &&
                     (head_cnt + 2'd1 == h_cnt_q);

    assign busy      = (state == st_run);
    assign run_start = accept;

    // bank read for the current column
    assign rd_en   = busy;
    assign rd_sel  = mat_cnt;
    assign rd_addr = `QKV_ADDR_W'(head_cnt * `QKV_X_LEN + col_cnt);

    ////////////////////////////////////////
    // beat and slot, one cycle behind the read
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_cnt_new) begin
            beat     <= '0;
            slot     <= '0;
            end_pipe <= '0;
        end else begin
            beat.valid <= busy;
            beat.first <= busy && (col_cnt == '0);
            beat.last  <= busy && col_end;
            beat.x     <= x_vec[col_cnt];
            end_pipe   <= {end_pipe[0], run_end};
            if (busy) begin
                slot.head <= head_cnt[`QKV_HEAD_W-1:0];
                slot.sel  <= mat_cnt;
            end
        end
    end

    ////////////////////////////////////////
    // run FSM
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_cnt_new) begin
            state    <= st_idle;
            done     <= 1'b1;
            h_cnt_q  <= '0;
            head_cnt <= '0;
            mat_cnt  <= mat_q;
            col_cnt  <= '0;
        end else begin
            if (end_pipe[1]) begin
                done <= 1'b1;
            end
            case (state)
                st_idle: begin
                    if (accept) begin
                        state    <= st_run;
                        done     <= 1'b0;
                        h_cnt_q  <= h_count;
                        head_cnt <= '0;
                        mat_cnt  <= mat_q;
                        col_cnt  <= '0;
                    end
                end
                st_run: begin
                    col_cnt <= col_cnt + 1'b1;
                    if (col_end) begin
                        col_cnt <= '0;
                        // q, k, v for a head, then on to the next head
                        case (mat_cnt)
                            mat_q: mat_cnt <= mat_k;
                            mat_k: mat_cnt <= mat_v;
                            default: begin
                                mat_cnt  <= mat_q;
                                head_cnt <= head_cnt + 2'd1;
                            end
                        endcase
                        if (run_end) begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // beats only flow while an open run holds done low
    a_beat_in_run: assert property (@(posedge clk) disable iff (rst_cnt_new)
        (beat.valid || beat.first) |-> !done);

endmodule

`default_nettype wire

// ==== hw/weight_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "qkv_defs.svh"

module weight_store
    import qkv_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_cnt_new,
    input  logic                   busy,
    input  wr_req_t                wr_req,
    input  logic                   rd_en,
    input  mat_sel_t               rd_sel,
    input  logic [`QKV_ADDR_W-1:0] rd_addr,
    output wrow_t                  rd_data
);

    localparam int depth = `QKV_H_MAX * `QKV_X_LEN;

    wrow_t bank_q [depth];
    wrow_t bank_k [depth];
    wrow_t bank_v [depth];

    logic wr_ok;

    // external port is locked out while a run reads the banks
    assign wr_ok = wr_req.en && wr_req.wr && !busy;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            case (wr_req.sel)
                mat_q:   bank_q[wr_req.addr] <= wr_req.data;
                mat_k:   bank_k[wr_req.addr] <= wr_req.data;
                mat_v:   bank_v[wr_req.addr] <= wr_req.data;
                default: ;
            endcase
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rst_cnt_new) begin
            rd_data <= '0;
        end else if (rd_en) begin
            case (rd_sel)
                mat_q:   rd_data <= bank_q[rd_addr];
                mat_k:   rd_data <= bank_k[rd_addr];
                mat_v:   rd_data <= bank_v[rd_addr];
                default: rd_data <= '0;
            endcase
        end
    end

    // reads only come from the sequencer during a run
    a_rd_in_run: assert property (@(posedge clk) disable iff (rst_cnt_new)
        rd_en |-> busy);

endmodule

`default_nettype wire

// ==== hw/qkv_pkg.sv ====
`default_nettype none

`include "qkv_defs.svh"

package qkv_pkg;

    typedef logic [`QKV_DW-1:0] word_t;

    // double width so the dot product can wrap cleanly
    typedef logic [2*`QKV_DW-1:0] acc_t;

    typedef enum logic [1:0] {
        mat_q = 2'd0,
        mat_k = 2'd1,
        mat_v = 2'd2
    } mat_sel_t;

    typedef word_t [`QKV_X_LEN-1:0] x_vec_t;

    // one weight per lane, entry h*X_LEN+c is column c of head h
    typedef word_t [`QKV_DIM-1:0] wrow_t;

    typedef struct packed {
        logic                   en;
        logic                   wr;
        mat_sel_t               sel;
        logic [`QKV_ADDR_W-1:0] addr;
        wrow_t                  data;
    } wr_req_t;

    // broadcast to every lane
    typedef struct packed {
        logic  valid;
        logic  first;
        logic  last;
        word_t x;
    } lane_beat_t;

    typedef word_t [`QKV_DIM-1:0] proj_t;

    typedef struct packed {
        proj_t q;
        proj_t k;
        proj_t v;
    } head_res_t;

    // head 0 sits at index 0
    typedef head_res_t [`QKV_H_MAX-1:0] qkv_frame_t;

    typedef struct packed {
        logic [`QKV_HEAD_W-1:0] head;
        mat_sel_t               sel;
    } slot_t;

endpackage

`default_nettype wire

// ==== hw/qkv_defs.svh ====
`ifndef QKV_DEFS_SVH
`define QKV_DEFS_SVH

////////////////////////////////////////
// projection engine sizing
////////////////////////////////////////

// width of one data word
`define QKV_DW 8

// words in the input vector x
`define QKV_X_LEN 8

// words per projection, also the lane count
`define QKV_DIM 4

// largest head count a run may ask for
`define QKV_H_MAX 2

// weight address, covers QKV_H_MAX * QKV_X_LEN entries
`define QKV_ADDR_W 4

// head index width, clog2 of QKV_H_MAX
`define QKV_HEAD_W 1

`endif
